// File: all.f
source/neuron_pkg.sv
source/pool_sequencer.sv
source/pool_config.sv
source/noise_lfsr.sv
source/drive_current.sv
source/izh_neuron_core.sv
source/neuron_pool_top.sv
tb/tb_neuron_pool.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_neuron_pool -f all.f || exit 1
result=$(./obj_dir/Vtb_neuron_pool)
echo "$result"
echo "$result" | grep -q "SIMULATION PASSED" && exit 0 || exit 1

// File: tb/tb_neuron_pool.sv
`default_nettype none

module tb_neuron_pool;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NN_BITS      = 3;
    localparam int N_NEURONS    = 2 ** NN_BITS;
    localparam int SWEEP_CYCLES = 4 * N_NEURONS;
    // 1.5 in fixed point, enough to make every neuron fire
    localparam neuron_pkg::fix18_t STRONG_DRIVE = 18'sh1_8000;
    localparam longint FIX_MAX = 131071;
    localparam longint FIX_MIN = -131072;

    logic                  neuron_clk;
    logic                  reset_sim;
    neuron_pkg::fix18_t    syn_current;
    logic                  cfg_write;
    neuron_pkg::cfg_addr_t cfg_addr;
    neuron_pkg::fix18_t    cfg_data;
    neuron_pkg::fix18_t    cfg_rdata;
    neuron_pkg::fix18_t    drive_out;
    logic                  spike;
    logic [NN_BITS-1:0]    spike_id;
    logic                  sweep_start;

    int     errors;
    int     checks;
    integer seed;

    neuron_pool_top #(
        .NN_BITS (NN_BITS)
    ) uut (
        .i_neuron_clk    (neuron_clk),
        .i_reset_sim     (reset_sim),
        .i_syn_current   (syn_current),
        .i_cfg_write     (cfg_write),
        .i_cfg_addr      (cfg_addr),
        .i_cfg_data      (cfg_data),
        .o_cfg_rdata     (cfg_rdata),
        .o_drive_current (drive_out),
        .o_spike         (spike),
        .o_spike_id      (spike_id),
        .o_sweep_start   (sweep_start)
    );

    // 4 ns period
    initial neuron_clk = 1'b0;
    always #2 neuron_clk = ~neuron_clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [17:0] got,
                               input logic [17:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // reference scaling: (current * gain) >> 16, clamped to 18 bits
    function automatic neuron_pkg::fix18_t expected_drive(input neuron_pkg::fix18_t cur,
                                                          input neuron_pkg::fix18_t gain);
        longint scaled;
        neuron_pkg::fix18_t r;
        scaled = (longint'(cur) * longint'(gain)) >>> 16;
        if (scaled > FIX_MAX) begin
            r = 18'sh1_FFFF;
        end else if (scaled < FIX_MIN) begin
            r = 18'sh2_0000;
        end else begin
            r = scaled[17:0];
        end
        return r;
    endfunction

    task automatic apply_reset();
        @(posedge neuron_clk);
        reset_sim <= 1'b1;
        repeat (3) @(posedge neuron_clk);
        reset_sim <= 1'b0;
    endtask

    // one-cycle write strobe, register takes it on the second edge
    task automatic write_reg(input neuron_pkg::cfg_addr_t addr, input neuron_pkg::fix18_t data);
        @(posedge neuron_clk);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_data  <= data;
        @(posedge neuron_clk);
        cfg_write <= 1'b0;
    endtask

    // readback is combinational, sampled mid-cycle
    task automatic read_reg(input neuron_pkg::cfg_addr_t addr, output neuron_pkg::fix18_t data);
        @(posedge neuron_clk);
        cfg_addr <= addr;
        @(negedge neuron_clk);
        data = cfg_rdata;
    endtask

    // counts cycles up to the next sweep strobe
    // once aligned, a spike must sit in WRITE of the neuron the schedule is on
    task automatic wait_sweep_start(input logic aligned, output int cycles, output int spikes);
        logic seen;
        cycles = 0;
        spikes = 0;
        seen   = 1'b0;
        while (!seen && cycles < 4 * SWEEP_CYCLES) begin
            @(negedge neuron_clk);
            cycles++;
            seen = sweep_start;
            if (aligned && spike) begin
                spikes++;
                // WRITE is the fourth cycle of each neuron slot
                check_value("o_spike phase", 18'(cycles % 4), 18'd3);
                check_value("o_spike_id", 18'(spike_id),
                            18'((cycles % SWEEP_CYCLES) / 4));
            end
        end
        if (!seen) begin
            errors++;
            $display("Timeout: o_sweep_start did not pulse within %0d cycles", cycles);
        end
    endtask

    task automatic drive_case(input neuron_pkg::fix18_t cur, input neuron_pkg::fix18_t gain);
        write_reg(neuron_pkg::REG_GAIN, gain);
        @(posedge neuron_clk);
        syn_current <= cur;
        // registered one cycle after the input change
        @(posedge neuron_clk);
        @(negedge neuron_clk);
        check_value("o_drive_current", drive_out, expected_drive(cur, gain));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic reset_defaults();
        neuron_pkg::fix18_t data;
        @(negedge neuron_clk);
        check_value("o_spike", 18'(spike), 18'd0);
        check_value("o_sweep_start", 18'(sweep_start), 18'd0);
        check_value("o_drive_current", drive_out, 18'd0);
        read_reg(neuron_pkg::REG_GAIN, data);
        check_value("gain register", data, neuron_pkg::GAIN_RESET_DEFAULT);
        read_reg(neuron_pkg::REG_NOISE, data);
        check_value("noise register", data, 18'd0);
        read_reg(neuron_pkg::REG_C, data);
        check_value("c register", data, neuron_pkg::C_RESET_DEFAULT);
        read_reg(neuron_pkg::REG_D, data);
        check_value("d register", data, neuron_pkg::D_RESET_DEFAULT);
    endtask

    task automatic config_readback();
        neuron_pkg::fix18_t val;
        neuron_pkg::fix18_t data;
        for (int a = 0; a < 4; a++) begin
            val = 18'($random(seed));
            write_reg(2'(a), val);
            read_reg(2'(a), data);
            if (2'(a) == neuron_pkg::REG_NOISE) begin
                // enable bit only
                check_value("o_cfg_rdata[0]", 18'(data[0]), 18'(val[0]));
            end else begin
                check_value("o_cfg_rdata", data, val);
            end
        end
        // back to defaults for the neuron tests
        write_reg(neuron_pkg::REG_GAIN, neuron_pkg::GAIN_RESET_DEFAULT);
        write_reg(neuron_pkg::REG_NOISE, 18'd0);
        write_reg(neuron_pkg::REG_C, neuron_pkg::C_RESET_DEFAULT);
        write_reg(neuron_pkg::REG_D, neuron_pkg::D_RESET_DEFAULT);
    endtask

    task automatic drive_arithmetic();
        neuron_pkg::fix18_t cur;
        neuron_pkg::fix18_t gain;
        logic [31:0] rnd;
        for (int i = 0; i < 16; i++) begin
            cur = 18'($random(seed));
            rnd = $random(seed);
            // every other case keeps gain below 1.0 so the result stays in range
            if (i % 2 == 0) begin
                gain = {2'b00, rnd[15:0]};
            end else begin
                gain = rnd[17:0];
            end
            drive_case(cur, gain);
        end
        // positive saturation
        drive_case(18'sh1_E000, 18'sh1_C000);
        drive_case(18'sh2_0000, 18'sh2_0000);
        // negative saturation
        drive_case(18'sh2_0000, 18'sh1_8000);
        drive_case(18'sh1_FFFF, 18'sh2_0000);
    endtask

    task automatic sweep_schedule();
        int cycles;
        int spikes;
        int total_spikes;
        write_reg(neuron_pkg::REG_GAIN, neuron_pkg::GAIN_RESET_DEFAULT);
        @(posedge neuron_clk);
        syn_current <= STRONG_DRIVE;
        total_spikes = 0;
        // first strobe only aligns
        wait_sweep_start(1'b0, cycles, spikes);
        for (int n = 0; n < 3; n++) begin
            wait_sweep_start(1'b1, cycles, spikes);
            total_spikes += spikes;
            check_value("o_sweep_start interval", 18'(cycles), 18'(SWEEP_CYCLES));
        end
        if (total_spikes == 0) begin
            errors++;
            $display("No spike appeared during three sweeps of strong drive");
        end
    endtask

    task automatic quiescence_and_firing();
        int spikes;
        int cycles;
        logic [N_NEURONS-1:0] fired;
        @(posedge neuron_clk);
        syn_current <= '0;
        // fresh state memory so every neuron starts at rest
        apply_reset();
        write_reg(neuron_pkg::REG_GAIN, 18'd0);
        // strong input that zero gain has to block
        @(posedge neuron_clk);
        syn_current <= STRONG_DRIVE;
        spikes = 0;
        repeat (10 * SWEEP_CYCLES) begin
            @(negedge neuron_clk);
            if (spike) begin
                spikes++;
            end
        end
        check_value("spike count at zero drive", 18'(spikes), 18'd0);

        write_reg(neuron_pkg::REG_GAIN, neuron_pkg::GAIN_RESET_DEFAULT);
        @(posedge neuron_clk);
        syn_current <= STRONG_DRIVE;
        fired  = '0;
        cycles = 0;
        while (fired != '1 && cycles < 200 * SWEEP_CYCLES) begin
            @(negedge neuron_clk);
            cycles++;
            if (spike) begin
                fired[spike_id] = 1'b1;
            end
        end
        if (fired != '1) begin
            errors++;
            $display("Timeout: not every neuron fired, fired mask is %h", fired);
        end
    endtask

    task automatic noise_bound();
        neuron_pkg::fix18_t first;
        logic distinct;
        write_reg(neuron_pkg::REG_GAIN, neuron_pkg::GAIN_RESET_DEFAULT);
        write_reg(neuron_pkg::REG_NOISE, 18'd1);
        @(posedge neuron_clk);
        syn_current <= '0;
        repeat (2) @(posedge neuron_clk);
        distinct = 1'b0;
        first    = '0;
        for (int i = 0; i < 100; i++) begin
            @(negedge neuron_clk);
            checks++;
            if (i == 0) begin
                first = drive_out;
            end else if (drive_out != first) begin
                distinct = 1'b1;
            end
            if (drive_out < 18'sd0 || drive_out > 18'sd63) begin
                errors++;
                $display("Mismatch o_drive_current: got %h, expected 0 to 3f", drive_out);
            end
        end
        if (!distinct) begin
            errors++;
            $display("Noise left the drive current constant over 100 samples");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        errors      = 0;
        checks      = 0;
        seed        = 32'hfd74bf74;
        reset_sim   = 1'b1;
        syn_current = '0;
        cfg_write   = 1'b0;
        cfg_addr    = neuron_pkg::REG_GAIN;
        cfg_data    = '0;
        apply_reset();

        reset_defaults();
        config_readback();
        drive_arithmetic();
        sweep_schedule();
        quiescence_and_firing();
        noise_bound();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/neuron_pool_top.sv
`default_nettype none

module neuron_pool_top #(
    parameter int NN_BITS = 3
) (
    input  wire                        i_neuron_clk,
    input  wire                        i_reset_sim,
    input  wire neuron_pkg::fix18_t    i_syn_current,
    input  wire                        i_cfg_write,
    input  wire neuron_pkg::cfg_addr_t i_cfg_addr,
    input  wire neuron_pkg::fix18_t    i_cfg_data,
    output wire neuron_pkg::fix18_t    o_cfg_rdata,
    output wire neuron_pkg::fix18_t    o_drive_current,
    output wire                        o_spike,
    output wire [NN_BITS-1:0]          o_spike_id,
    output wire                        o_sweep_start
);

    // schedule
    wire neuron_pkg::phase_t phase;
    wire [NN_BITS-1:0]       index;
    // configuration
    wire neuron_pkg::fix18_t gain;
    wire                     noise_en;
    wire neuron_pkg::fix18_t c_reset;
    wire neuron_pkg::fix18_t d_bump;
    // jitter source
    wire neuron_pkg::fix18_t noise;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////
    pool_sequencer #(
        .NN_BITS (NN_BITS)
    ) u_sequencer (
        .i_neuron_clk  (i_neuron_clk),
        .i_reset_sim   (i_reset_sim),
        .o_phase       (phase),
        .o_index       (index),
        .o_sweep_start (o_sweep_start)
    );

    pool_config u_config (
        .i_neuron_clk (i_neuron_clk),
        .i_reset_sim  (i_reset_sim),
        .i_cfg_write  (i_cfg_write),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_data   (i_cfg_data),
        .o_cfg_rdata  (o_cfg_rdata),
        .o_gain       (gain),
        .o_noise_en   (noise_en),
        .o_c          (c_reset),
        .o_d          (d_bump)
    );

    ////////////////////////////////////////////////////////////////////////////
    // shared drive current and the neuron core
    ////////////////////////////////////////////////////////////////////////////
    noise_lfsr u_noise (
        .i_neuron_clk (i_neuron_clk),
        .i_reset_sim  (i_reset_sim),
        .o_noise      (noise)
    );

    drive_current u_drive (
        .i_neuron_clk    (i_neuron_clk),
        .i_reset_sim     (i_reset_sim),
        .i_syn_current   (i_syn_current),
        .i_noise         (noise),
        .i_noise_en      (noise_en),
        .i_gain          (gain),
        .o_drive_current (o_drive_current)
    );

    izh_neuron_core #(
        .NN_BITS (NN_BITS)
    ) u_core (
        .i_neuron_clk    (i_neuron_clk),
        .i_reset_sim     (i_reset_sim),
        .i_phase         (phase),
        .i_index         (index),
        .i_drive_current (o_drive_current),
        .i_c             (c_reset),
        .i_d             (d_bump),
        .o_spike         (o_spike),
        .o_spike_id      (o_spike_id)
    );

endmodule

`default_nettype wire

// File: source/izh_neuron_core.sv
`default_nettype none

module izh_neuron_core #(
    parameter int NN_BITS = 3
) (
    input  wire                     i_neuron_clk,
    input  wire                     i_reset_sim,
    input  wire neuron_pkg::phase_t i_phase,
    input  wire [NN_BITS-1:0]       i_index,
    input  wire neuron_pkg::fix18_t i_drive_current,
    input  wire neuron_pkg::fix18_t i_c,
    input  wire neuron_pkg::fix18_t i_d,
    output logic                    o_spike,
    output logic [NN_BITS-1:0]      o_spike_id
);

    localparam int N_NEURONS = 2 ** NN_BITS;
    // a = 1/8, b = 1/4, time step 1/4, all as shifts
    localparam int SHIFT_A   = 3;
    localparam int SHIFT_B   = 2;
    localparam int SHIFT_TAU = 2;

    // headroom for the intermediate sums
    typedef logic signed [23:0] wide_t;

    // constant term 1.40
    localparam wide_t K_140 = 24'sd91750;

    // state memory, one entry per neuron
    neuron_pkg::fix18_t v_mem [N_NEURONS];
    neuron_pkg::fix18_t u_mem [N_NEURONS];
    // set once a neuron has been written back since reset
    logic [N_NEURONS-1:0] seeded;

    // state read in READ
    neuron_pkg::fix18_t v_q;
    neuron_pkg::fix18_t u_q;
    // updated state from COMPUTE
    neuron_pkg::fix18_t v_calc;
    neuron_pkg::fix18_t u_calc;

    logic signed [35:0] v_square;
    wide_t v_w;
    wide_t u_w;
    wide_t i_w;
    wide_t dv;
    wide_t v_next;
    wide_t u_next;
    wide_t u_bumped;
    logic fired;

    // clamp a wide value into fix18_t
    function automatic neuron_pkg::fix18_t sat18(input wide_t x);
        neuron_pkg::fix18_t r;
        if (x > wide_t'(neuron_pkg::FIX18_MAX)) begin
            r = neuron_pkg::FIX18_MAX;
        end else if (x < wide_t'(neuron_pkg::FIX18_MIN)) begin
            r = neuron_pkg::FIX18_MIN;
        end else begin
            r = x[17:0];
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // izhikevich step, v in units of 100 mV
    // 0.04*v^2 in mV becomes 4*v^2 here, 140 becomes 1.40
    ////////////////////////////////////////////////////////////////////////////
    assign v_w = wide_t'(v_q);
    assign u_w = wide_t'(u_q);
    assign i_w = wide_t'(i_drive_current);
    assign v_square = 36'(v_q) * 36'(v_q);

    // 4*v^2 is v*v scaled by 2^-14
    assign dv = wide_t'(v_square >>> 14) + (v_w <<< 2) + v_w + K_140 - u_w + i_w;
    assign v_next = v_w + (dv >>> SHIFT_TAU);
    // recovery follows b*v at rate a
    assign u_next = u_w + (((v_w >>> SHIFT_B) - u_w) >>> SHIFT_A);
    assign fired = (sat18(v_next) >= neuron_pkg::V_PEAK);

    // recovery after a spike
    assign u_bumped = wide_t'(u_calc) + wide_t'(i_d);

    ////////////////////////////////////////////////////////////////////////////
    // datapath and state memory
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_neuron_clk) begin
        if (i_phase == neuron_pkg::PH_READ) begin
            // untouched neurons start at rest, v = c and u = 0
            v_q <= seeded[i_index] ? v_mem[i_index] : i_c;
            u_q <= seeded[i_index] ? u_mem[i_index] : '0;
        end
        if (i_phase == neuron_pkg::PH_COMPUTE) begin
            v_calc <= sat18(v_next);
            u_calc <= sat18(u_next);
        end
        if (i_phase == neuron_pkg::PH_WRITE) begin
            // spike resets v and bumps u
            v_mem[i_index] <= o_spike ? i_c : v_calc;
            u_mem[i_index] <= o_spike ? sat18(u_bumped) : u_calc;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // spike event and seed flags
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_neuron_clk or posedge i_reset_sim) begin
        if (i_reset_sim) begin
            seeded     <= '0;
            o_spike    <= 1'b0;
            o_spike_id <= '0;
        end else begin
            // set on the COMPUTE edge, so high only during WRITE
            o_spike <= (i_phase == neuron_pkg::PH_COMPUTE) && fired;
            if (i_phase == neuron_pkg::PH_COMPUTE) begin
                o_spike_id <= i_index;
            end
            if (i_phase == neuron_pkg::PH_WRITE) begin
                seeded[i_index] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/drive_current.sv
`default_nettype none

module drive_current (
    input  wire                     i_neuron_clk,
    input  wire                     i_reset_sim,
    input  wire neuron_pkg::fix18_t i_syn_current,
    input  wire neuron_pkg::fix18_t i_noise,
    input  wire                     i_noise_en,
    input  wire neuron_pkg::fix18_t i_gain,
    output neuron_pkg::fix18_t      o_drive_current
);

    // noise after the enable gate
    neuron_pkg::fix18_t noise_sel;
    // synaptic input plus jitter
    neuron_pkg::fix18_t current_sum;
    // full product, 4 integer bits and 32 fraction bits
    logic signed [35:0] product;
    // product back in 18-bit format
    neuron_pkg::fix18_t product_sat;

    assign noise_sel   = i_noise_en ? i_noise : '0;
    assign current_sum = i_syn_current + noise_sel;
    assign product     = 36'(current_sum) * 36'(i_gain);

    ////////////////////////////////////////////////////////////////////////////
    // scale back by 16 and clamp
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        // shifted result fits when the top three bits agree
        if ((product[35:33] == 3'b000) || (product[35:33] == 3'b111)) begin
            product_sat = product[33:16];
        end else if (product[35]) begin
            product_sat = neuron_pkg::FIX18_MIN;
        end else begin
            product_sat = neuron_pkg::FIX18_MAX;
        end
    end

    // one cycle from input or gain change to output
    always_ff @(posedge i_neuron_clk or posedge i_reset_sim) begin
        if (i_reset_sim) begin
            o_drive_current <= '0;
        end else begin
            o_drive_current <= product_sat;
        end
    end

endmodule

`default_nettype wire

// File: source/noise_lfsr.sv
`default_nettype none

module noise_lfsr (
    input  wire                 i_neuron_clk,
    input  wire                 i_reset_sim,
    output neuron_pkg::fix18_t  o_noise
);

    // nonzero start value, all-zero state would lock up
    localparam logic [31:0] LFSR_SEED = 32'h1D87_2B41;
    // taps 32,30,26,25, maximal length for right shift
    localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;

    logic [31:0] lfsr;

    ////////////////////////////////////////////////////////////////////////////
    // galois form, one step per clock
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_neuron_clk or posedge i_reset_sim) begin
        if (i_reset_sim) begin
            lfsr <= LFSR_SEED;
        end else begin
            // feedback from bit 0 toggles the tap positions
            lfsr <= {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'd0);
        end
    end

    // six low bits as fraction LSBs
    // always non-negative, at most 63 LSBs
    assign o_noise = {12'd0, lfsr[5:0]};

endmodule

`default_nettype wire

// File: source/pool_config.sv
`default_nettype none

module pool_config (
    input  wire                     i_neuron_clk,
    input  wire                     i_reset_sim,
    input  wire                     i_cfg_write,
    input  wire neuron_pkg::cfg_addr_t i_cfg_addr,
    input  wire neuron_pkg::fix18_t i_cfg_data,
    output neuron_pkg::fix18_t      o_cfg_rdata,
    output neuron_pkg::fix18_t      o_gain,
    output logic                    o_noise_en,
    output neuron_pkg::fix18_t      o_c,
    output neuron_pkg::fix18_t      o_d
);

    ////////////////////////////////////////////////////////////////////////////
    // steering registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_neuron_clk or posedge i_reset_sim) begin
        if (i_reset_sim) begin
            o_gain     <= neuron_pkg::GAIN_RESET_DEFAULT;
            o_noise_en <= 1'b0;
            o_c        <= neuron_pkg::C_RESET_DEFAULT;
            o_d        <= neuron_pkg::D_RESET_DEFAULT;
        end else if (i_cfg_write) begin
            case (i_cfg_addr)
                neuron_pkg::REG_GAIN: begin
                    o_gain <= i_cfg_data;
                end
                neuron_pkg::REG_NOISE: begin
                    // single enable bit
                    o_noise_en <= i_cfg_data[0];
                end
                neuron_pkg::REG_C: begin
                    o_c <= i_cfg_data;
                end
                default: begin
                    o_d <= i_cfg_data;
                end
            endcase
        end
    end

    // readback of the addressed register, no latency
    always_comb begin
        case (i_cfg_addr)
            neuron_pkg::REG_GAIN: begin
                o_cfg_rdata = o_gain;
            end
            neuron_pkg::REG_NOISE: begin
                // upper bits read as zero
                o_cfg_rdata = {17'd0, o_noise_en};
            end
            neuron_pkg::REG_C: begin
                o_cfg_rdata = o_c;
            end
            default: begin
                o_cfg_rdata = o_d;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/pool_sequencer.sv
`default_nettype none

module pool_sequencer #(
    parameter int NN_BITS = 3
) (
    input  wire                     i_neuron_clk,
    input  wire                     i_reset_sim,
    output neuron_pkg::phase_t      o_phase,
    output logic [NN_BITS-1:0]      o_index,
    output logic                    o_sweep_start
);

    // high while the last neuron of the sweep is being processed
    logic last_neuron;

    assign last_neuron = &o_index;

    ////////////////////////////////////////////////////////////////////////////
    // four phases per neuron
    // index moves on entry to ADVANCE so it is stable for all four phases
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_neuron_clk or posedge i_reset_sim) begin
        if (i_reset_sim) begin
            o_phase       <= neuron_pkg::PH_ADVANCE;
            o_index       <= '0;
            o_sweep_start <= 1'b0;
        end else begin
            // strobe defaults low, single cycle
            o_sweep_start <= 1'b0;
            case (o_phase)
                neuron_pkg::PH_ADVANCE: begin
                    o_phase <= neuron_pkg::PH_READ;
                end
                neuron_pkg::PH_READ: begin
                    o_phase <= neuron_pkg::PH_COMPUTE;
                end
                neuron_pkg::PH_COMPUTE: begin
                    o_phase <= neuron_pkg::PH_WRITE;
                end
                default: begin
                    // wrap to next neuron
                    o_phase <= neuron_pkg::PH_ADVANCE;
                    o_index <= o_index + 1'b1;
                    // registered so it lands on ADVANCE of index 0
                    o_sweep_start <= last_neuron;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/neuron_pkg.sv
`default_nettype none

package neuron_pkg;

    // signed fixed point, 2 integer bits and 16 fraction bits
    // v, u, c, d, currents and gain all use this format
    typedef logic signed [17:0] fix18_t;

    // saturation limits of fix18_t
    localparam fix18_t FIX18_MAX = 18'sh1_FFFF;
    localparam fix18_t FIX18_MIN = 18'sh2_0000;

    // per-neuron schedule, one phase per clock
    typedef enum logic [1:0] {
        PH_ADVANCE = 2'd0,
        PH_READ    = 2'd1,
        PH_COMPUTE = 2'd2,
        PH_WRITE   = 2'd3
    } phase_t;

    // configuration register map
    typedef logic [1:0] cfg_addr_t;
    localparam cfg_addr_t REG_GAIN  = 2'd0;
    localparam cfg_addr_t REG_NOISE = 2'd1;
    localparam cfg_addr_t REG_C     = 2'd2;
    localparam cfg_addr_t REG_D     = 2'd3;

    // spike threshold 0.30
    localparam fix18_t V_PEAK             = 18'sh0_4CCD;
    // reset potential -0.65
    localparam fix18_t C_RESET_DEFAULT    = 18'sh3_599A;
    // recovery bump 0.08
    localparam fix18_t D_RESET_DEFAULT    = 18'sh0_147A;
    // unity gain
    localparam fix18_t GAIN_RESET_DEFAULT = 18'sh1_0000;

endpackage

`default_nettype wire
